/* source/rn_cfg_pkg.sv */
// Back end configuration: sizes, register bank type and index types.
package rn_cfg_pkg;

  // Data path width.
  localparam int XLEN_W = 32;

  // Architectural registers per bank.
  localparam int ARCH_REGS = 8;
  localparam int ARCH_W = 3;

  // Physical registers per bank.
  localparam int RNID_SIZE = 16;
  localparam int RNID_W = 4;

  // Write buses, ALU on bus 0 and multiplier on bus 1.
  localparam int TGT_BUS_SIZE = 2;

  // Read ports per bank.
  localparam int RD_PORT_SIZE = 2;

  // In-order issue queue.
  localparam int IQ_DEPTH = 8;

  // Client tag carried through to the write-back report.
  localparam int TAG_W = 4;

  typedef enum logic {
    GPR = 1'b0,
    FPR = 1'b1
  } reg_type_e;

  typedef logic [RNID_W-1:0] rnid_t;
  typedef logic [ARCH_W-1:0] arch_t;
  typedef logic [XLEN_W-1:0] data_t;

endpackage

/* source/rn_uop_pkg.sv */
// Micro-op definitions: opcodes, pipeline structs and operand bank decode.
package rn_uop_pkg;

  import rn_cfg_pkg::*;

  typedef enum logic [2:0] {
    OP_ADD   = 3'd0,
    OP_SUB   = 3'd1,
    OP_XOR   = 3'd2,
    OP_LI    = 3'd3,
    OP_MUL   = 3'd4,
    OP_FADD  = 3'd5,
    OP_FMVXF = 3'd6,
    OP_FMVFX = 3'd7
  } opcode_e;

  // Micro-op as delivered by the client.
  typedef struct packed {
    logic             valid;
    logic [TAG_W-1:0] tag;
    opcode_e          opcode;
    arch_t            rd;
    arch_t            rs1;
    arch_t            rs2;
    logic [15:0]      imm;
  } uop_t;

  // Operation leaving the issue queue.
  typedef struct packed {
    logic             valid;
    logic [TAG_W-1:0] tag;
    opcode_e          opcode;
    reg_type_e        rd_type;
    arch_t            rd_arch;
    rnid_t            rd_rnid;
    rnid_t            old_rnid;
    logic [15:0]      imm;
  } issue_t;

  // One target bus. Tag, arch index and old mapping ride along for reporting and freeing.
  typedef struct packed {
    logic             valid;
    reg_type_e        rd_type;
    rnid_t            rd_rnid;
    data_t            rd_data;
    logic [TAG_W-1:0] tag;
    arch_t            rd_arch;
    rnid_t            old_rnid;
  } phy_wr_t;

  // Write-back report at the top level.
  typedef struct packed {
    logic             valid;
    logic [TAG_W-1:0] tag;
    reg_type_e        rd_type;
    arch_t            rd_arch;
    data_t            data;
  } wb_info_t;

  // Both sources always sit in the same bank.
  function automatic reg_type_e op_src_type(opcode_e op);
    return (op == OP_FADD || op == OP_FMVFX) ? FPR : GPR;
  endfunction

  function automatic reg_type_e op_dst_type(opcode_e op);
    return (op == OP_FADD || op == OP_FMVXF) ? FPR : GPR;
  endfunction

  function automatic logic op_uses_rs1(opcode_e op);
    return op != OP_LI;
  endfunction

  function automatic logic op_uses_rs2(opcode_e op);
    return !(op inside {OP_LI, OP_FMVXF, OP_FMVFX});
  endfunction

endpackage

/* source/phy_registers.sv */
// Physical register bank with write-bus selection and combinational read ports.
`timescale 1ns/10ps

module phy_registers #(
  parameter rn_cfg_pkg::reg_type_e REG_TYPE = rn_cfg_pkg::GPR
) (
  input  logic                i_clk,
  input  logic                i_reset_n,
  input  rn_cfg_pkg::rnid_t   i_rd_rnid [rn_cfg_pkg::RD_PORT_SIZE],
  output rn_cfg_pkg::data_t   o_rd_data [rn_cfg_pkg::RD_PORT_SIZE],
  input  rn_uop_pkg::phy_wr_t i_phy_wr  [rn_cfg_pkg::TGT_BUS_SIZE]
);

  import rn_cfg_pkg::*;
  import rn_uop_pkg::*;

  data_t                   r_regs [RNID_SIZE];
  logic [TGT_BUS_SIZE-1:0] w_wr_valid;
  logic [RNID_SIZE-1:0]    w_we;
  logic [RNID_SIZE-1:0]    w_multi;
  data_t                   w_wdata [RNID_SIZE];

  // A bus only counts for this bank when its type matches.
  always_comb begin
    for (int w = 0; w < TGT_BUS_SIZE; w++) begin
      w_wr_valid[w] = i_phy_wr[w].valid && (i_phy_wr[w].rd_type == REG_TYPE);
    end
  end

  // Per register, pick the bus that carries its index.
  always_comb begin
    for (int r = 0; r < RNID_SIZE; r++) begin
      w_we[r]    = 1'b0;
      w_multi[r] = 1'b0;
      w_wdata[r] = '0;
      for (int w = 0; w < TGT_BUS_SIZE; w++) begin
        if (w_wr_valid[w] && (i_phy_wr[w].rd_rnid == RNID_W'(r))) begin
          w_multi[r] = w_multi[r] | w_we[r];
          w_we[r]    = 1'b1;
          w_wdata[r] = i_phy_wr[w].rd_data;
        end
      end
    end
    // GPR register 0 backs x0 and never takes a write.
    if (REG_TYPE == GPR) begin
      w_we[0]    = 1'b0;
      w_multi[0] = 1'b0;
    end
  end

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      for (int r = 0; r < RNID_SIZE; r++) begin
        r_regs[r] <= '0;
      end
    end else begin
      for (int r = 0; r < RNID_SIZE; r++) begin
        if (w_we[r]) begin
          r_regs[r] <= w_wdata[r];
        end
      end
    end
  end

  always_comb begin
    for (int p = 0; p < RD_PORT_SIZE; p++) begin
      o_rd_data[p] = ((REG_TYPE == GPR) && (i_rd_rnid[p] == '0)) ? '0 : r_regs[i_rd_rnid[p]];
    end
  end

  // Rename hands out each register once, so the ALU and the multiplier never collide.
  a_no_dual_write : assert property (@(posedge i_clk) disable iff (!i_reset_n) w_multi == '0)
    else $error("two write buses target the same physical register");

endmodule

/* source/rename_map.sv */
// Rename stage: per-bank map table and circular free list of physical registers.
`timescale 1ns/10ps

module rename_map (
  input  logic                i_clk,
  input  logic                i_reset_n,
  input  rn_uop_pkg::uop_t    i_uop,
  output rn_cfg_pkg::rnid_t   o_rs1_rnid,
  output rn_cfg_pkg::rnid_t   o_rs2_rnid,
  output rn_cfg_pkg::rnid_t   o_rd_rnid,
  output rn_cfg_pkg::rnid_t   o_old_rnid,
  input  rn_uop_pkg::phy_wr_t i_phy_wr [rn_cfg_pkg::TGT_BUS_SIZE]
);

  import rn_cfg_pkg::*;
  import rn_uop_pkg::*;

  // Registers beyond the initial one-to-one mapping start out free.
  localparam int FL_DEPTH = RNID_SIZE - ARCH_REGS;
  localparam int FL_PTR_W = $clog2(FL_DEPTH);
  localparam int FL_CNT_W = FL_PTR_W + 1;

  rnid_t                   r_map  [2][ARCH_REGS];
  rnid_t                   r_fl   [2][FL_DEPTH];
  logic [FL_PTR_W-1:0]     r_head [2];
  logic [FL_PTR_W-1:0]     r_tail [2];
  logic [FL_CNT_W-1:0]     r_cnt  [2];

  reg_type_e               w_src_type;
  reg_type_e               w_dst_type;
  logic                    w_rd_x0;
  logic [1:0]              w_pop;
  logic [1:0]              w_empty;
  logic [TGT_BUS_SIZE-1:0] w_push     [2];
  logic [FL_PTR_W-1:0]     w_slot     [2][TGT_BUS_SIZE];
  logic [FL_CNT_W-1:0]     w_push_cnt [2];

  always_comb begin
    w_src_type = op_src_type(i_uop.opcode);
    w_dst_type = op_dst_type(i_uop.opcode);
    w_rd_x0    = (w_dst_type == GPR) && (i_uop.rd == '0);
    o_rs1_rnid = r_map[w_src_type][i_uop.rs1];
    o_rs2_rnid = r_map[w_src_type][i_uop.rs2];
    o_old_rnid = r_map[w_dst_type][i_uop.rd];
    // x0 keeps physical register 0 and takes nothing from the free list.
    o_rd_rnid  = w_rd_x0 ? '0 : r_fl[w_dst_type][r_head[w_dst_type]];
  end

  // Pops and pushes per bank, with pushes packed into consecutive slots.
  always_comb begin
    for (int b = 0; b < 2; b++) begin
      w_pop[b]      = i_uop.valid && !w_rd_x0 && (int'(w_dst_type) == b);
      w_empty[b]    = (r_cnt[b] == '0);
      w_push_cnt[b] = '0;
      for (int w = 0; w < TGT_BUS_SIZE; w++) begin
        w_push[b][w] = i_phy_wr[w].valid && (int'(i_phy_wr[w].rd_type) == b) &&
                       !((b == int'(GPR)) && (i_phy_wr[w].old_rnid == '0));
        w_slot[b][w] = r_tail[b] + w_push_cnt[b][FL_PTR_W-1:0];
        w_push_cnt[b] = w_push_cnt[b] + FL_CNT_W'(w_push[b][w]);
      end
    end
  end

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      for (int b = 0; b < 2; b++) begin
        for (int a = 0; a < ARCH_REGS; a++) begin
          r_map[b][a] <= RNID_W'(a);
        end
        for (int f = 0; f < FL_DEPTH; f++) begin
          r_fl[b][f] <= RNID_W'(ARCH_REGS + f);
        end
        r_head[b] <= '0;
        r_tail[b] <= '0;
        r_cnt[b]  <= FL_CNT_W'(FL_DEPTH);
      end
    end else begin
      for (int b = 0; b < 2; b++) begin
        for (int w = 0; w < TGT_BUS_SIZE; w++) begin
          if (w_push[b][w]) begin
            r_fl[b][w_slot[b][w]] <= i_phy_wr[w].old_rnid;
          end
        end
        r_tail[b] <= r_tail[b] + w_push_cnt[b][FL_PTR_W-1:0];
        if (w_pop[b]) begin
          r_map[b][i_uop.rd] <= o_rd_rnid;
          r_head[b]          <= r_head[b] + 1'b1;
        end
        r_cnt[b] <= r_cnt[b] + w_push_cnt[b] - FL_CNT_W'(w_pop[b]);
      end
    end
  end

  // The client's outstanding limit keeps a free register available.
  a_fl_no_underflow : assert property (@(posedge i_clk) disable iff (!i_reset_n)
    (w_pop & w_empty) == '0)
    else $error("free list popped while empty");

endmodule

/* source/exec_units.sv */
// Execution units: one-cycle ALU on bus 0 and two-stage multiplier on bus 1.
`timescale 1ns/10ps

module exec_units (
  input  logic                i_clk,
  input  logic                i_reset_n,
  input  rn_uop_pkg::issue_t  i_issue,
  input  rn_cfg_pkg::data_t   i_gpr_rd_data [rn_cfg_pkg::RD_PORT_SIZE],
  input  rn_cfg_pkg::data_t   i_fpr_rd_data [rn_cfg_pkg::RD_PORT_SIZE],
  output rn_uop_pkg::phy_wr_t o_phy_wr      [rn_cfg_pkg::TGT_BUS_SIZE]
);

  import rn_cfg_pkg::*;
  import rn_uop_pkg::*;

  data_t       w_src1;
  data_t       w_src2;
  data_t       w_alu_res;
  logic        w_is_mul;
  data_t       w_mul_lo;
  logic [15:0] w_mul_hi;

  logic        r_alu_vld;
  phy_wr_t     r_alu_wr;
  logic        r_mul1_vld;
  issue_t      r_mul1_op;
  data_t       r_mul1_lo;
  logic [15:0] r_mul1_hi;
  logic        r_mul2_vld;
  phy_wr_t     r_mul2_wr;

  function automatic phy_wr_t make_wr(issue_t op, data_t data);
    phy_wr_t wr;
    wr.valid    = op.valid;
    wr.rd_type  = op.rd_type;
    wr.rd_rnid  = op.rd_rnid;
    wr.rd_data  = data;
    wr.tag      = op.tag;
    wr.rd_arch  = op.rd_arch;
    wr.old_rnid = op.old_rnid;
    return wr;
  endfunction

  // Both banks are read at the same index; the opcode picks the bank.
  always_comb begin
    w_src1   = (op_src_type(i_issue.opcode) == FPR) ? i_fpr_rd_data[0] : i_gpr_rd_data[0];
    w_src2   = (op_src_type(i_issue.opcode) == FPR) ? i_fpr_rd_data[1] : i_gpr_rd_data[1];
    w_is_mul = (i_issue.opcode == OP_MUL);
  end

  always_comb begin
    case (i_issue.opcode)
      OP_ADD, OP_FADD:     w_alu_res = w_src1 + w_src2;
      OP_SUB:              w_alu_res = w_src1 - w_src2;
      OP_XOR:              w_alu_res = w_src1 ^ w_src2;
      OP_LI:               w_alu_res = {16'h0000, i_issue.imm};
      OP_FMVXF, OP_FMVFX:  w_alu_res = w_src1;
      default:             w_alu_res = '0;
    endcase
  end

  // Multiplier split: low half of b in stage 1, upper cross term folded in stage 2.
  always_comb begin
    w_mul_lo = w_src1 * {16'h0000, w_src2[15:0]};
    w_mul_hi = w_src1[15:0] * w_src2[31:16];
  end

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_alu_vld  <= 1'b0;
      r_mul1_vld <= 1'b0;
      r_mul2_vld <= 1'b0;
    end else begin
      r_alu_vld  <= i_issue.valid && !w_is_mul;
      r_mul1_vld <= i_issue.valid && w_is_mul;
      r_mul2_vld <= r_mul1_vld;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_issue.valid && !w_is_mul) begin
      r_alu_wr <= make_wr(i_issue, w_alu_res);
    end
    if (i_issue.valid && w_is_mul) begin
      r_mul1_op <= i_issue;
      r_mul1_lo <= w_mul_lo;
      r_mul1_hi <= w_mul_hi;
    end
    if (r_mul1_vld) begin
      r_mul2_wr <= make_wr(r_mul1_op, r_mul1_lo + {r_mul1_hi, 16'h0000});
    end
  end

  always_comb begin
    o_phy_wr[0]       = r_alu_wr;
    o_phy_wr[0].valid = r_alu_vld;
    o_phy_wr[1]       = r_mul2_wr;
    o_phy_wr[1].valid = r_mul2_vld;
  end

endmodule

/* source/issue_ctrl.sv */
// Issue control: in-order issue queue, busy table and source hazard check.
`timescale 1ns/10ps

module issue_ctrl (
  input  logic                i_clk,
  input  logic                i_reset_n,
  input  rn_uop_pkg::uop_t    i_uop,
  output rn_uop_pkg::uop_t    o_ren_uop,
  input  rn_cfg_pkg::rnid_t   i_ren_rs1,
  input  rn_cfg_pkg::rnid_t   i_ren_rs2,
  input  rn_cfg_pkg::rnid_t   i_ren_rd,
  input  rn_cfg_pkg::rnid_t   i_ren_old,
  output rn_cfg_pkg::rnid_t   o_rd_rnid [rn_cfg_pkg::RD_PORT_SIZE],
  output rn_uop_pkg::issue_t  o_issue,
  input  rn_uop_pkg::phy_wr_t i_phy_wr  [rn_cfg_pkg::TGT_BUS_SIZE]
);

  import rn_cfg_pkg::*;
  import rn_uop_pkg::*;

  localparam int PTR_W = $clog2(IQ_DEPTH);
  localparam int CNT_W = PTR_W + 1;

  // Queue entry keeps the renamed sources next to the issued fields.
  typedef struct packed {
    issue_t op;
    rnid_t  rs1;
    rnid_t  rs2;
  } iq_entry_t;

  iq_entry_t                  r_iq [IQ_DEPTH];
  logic [PTR_W-1:0]           r_wptr;
  logic [PTR_W-1:0]           r_rptr;
  logic [CNT_W-1:0]           r_count;
  logic [1:0][RNID_SIZE-1:0]  r_busy;

  iq_entry_t  w_new;
  iq_entry_t  w_head;
  reg_type_e  w_head_src;
  logic       w_enq;
  logic       w_deq;
  logic       w_rs1_busy;
  logic       w_rs2_busy;
  logic       w_set_busy;

  // Rename sees the micro-op in the cycle it arrives.
  assign o_ren_uop = i_uop;

  always_comb begin
    w_enq           = i_uop.valid;
    w_new.op.valid  = 1'b1;
    w_new.op.tag    = i_uop.tag;
    w_new.op.opcode = i_uop.opcode;
    w_new.op.rd_type  = op_dst_type(i_uop.opcode);
    w_new.op.rd_arch  = i_uop.rd;
    w_new.op.rd_rnid  = i_ren_rd;
    w_new.op.old_rnid = i_ren_old;
    w_new.op.imm      = i_uop.imm;
    w_new.rs1 = i_ren_rs1;
    w_new.rs2 = i_ren_rs2;
    // GPR register 0 is never busy.
    w_set_busy = w_enq && !((w_new.op.rd_type == GPR) && (i_ren_rd == '0));
  end

  // Head issues once both of its sources have been written.
  always_comb begin
    w_head     = r_iq[r_rptr];
    w_head_src = op_src_type(w_head.op.opcode);
    w_rs1_busy = op_uses_rs1(w_head.op.opcode) && r_busy[w_head_src][w_head.rs1];
    w_rs2_busy = op_uses_rs2(w_head.op.opcode) && r_busy[w_head_src][w_head.rs2];
    w_deq      = (r_count != '0) && !w_rs1_busy && !w_rs2_busy;
    o_issue       = w_head.op;
    o_issue.valid = w_deq;
    o_rd_rnid[0]  = w_head.rs1;
    o_rd_rnid[1]  = w_head.rs2;
  end

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_wptr  <= '0;
      r_rptr  <= '0;
      r_count <= '0;
    end else begin
      if (w_enq) begin
        r_wptr <= r_wptr + 1'b1;
      end
      if (w_deq) begin
        r_rptr <= r_rptr + 1'b1;
      end
      r_count <= r_count + CNT_W'(w_enq) - CNT_W'(w_deq);
    end
  end

  always_ff @(posedge i_clk) begin
    if (w_enq) begin
      r_iq[r_wptr] <= w_new;
    end
  end

  // Bus writes clear, a new destination sets.
  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_busy <= '0;
    end else begin
      for (int w = 0; w < TGT_BUS_SIZE; w++) begin
        if (i_phy_wr[w].valid) begin
          r_busy[i_phy_wr[w].rd_type][i_phy_wr[w].rd_rnid] <= 1'b0;
        end
      end
      if (w_set_busy) begin
        r_busy[w_new.op.rd_type][w_new.op.rd_rnid] <= 1'b1;
      end
    end
  end

  // Relies on the client keeping at most eight micro-ops outstanding.
  a_iq_no_overflow : assert property (@(posedge i_clk) disable iff (!i_reset_n)
    ((r_count == CNT_W'(IQ_DEPTH)) && !w_deq) |-> !i_uop.valid)
    else $error("issue queue overflow");

endmodule

/* source/rn_backend_top.sv */
// Rename and execute back end top: issue control, rename, register banks and units.
`timescale 1ns/10ps

module rn_backend_top (
  input  logic                 i_clk,
  input  logic                 i_reset_n,
  input  rn_uop_pkg::uop_t     i_uop,
  output rn_uop_pkg::wb_info_t o_wb [rn_cfg_pkg::TGT_BUS_SIZE]
);

  import rn_cfg_pkg::*;
  import rn_uop_pkg::*;

  uop_t    ren_uop;
  rnid_t   ren_rs1;
  rnid_t   ren_rs2;
  rnid_t   ren_rd;
  rnid_t   ren_old;
  rnid_t   rd_rnid     [RD_PORT_SIZE];
  data_t   gpr_rd_data [RD_PORT_SIZE];
  data_t   fpr_rd_data [RD_PORT_SIZE];
  issue_t  issue;
  phy_wr_t phy_wr      [TGT_BUS_SIZE];

  issue_ctrl issue_ctrl_i (
    .i_clk     (i_clk),
    .i_reset_n (i_reset_n),
    .i_uop     (i_uop),
    .o_ren_uop (ren_uop),
    .i_ren_rs1 (ren_rs1),
    .i_ren_rs2 (ren_rs2),
    .i_ren_rd  (ren_rd),
    .i_ren_old (ren_old),
    .o_rd_rnid (rd_rnid),
    .o_issue   (issue),
    .i_phy_wr  (phy_wr)
  );

  rename_map rename_map_i (
    .i_clk      (i_clk),
    .i_reset_n  (i_reset_n),
    .i_uop      (ren_uop),
    .o_rs1_rnid (ren_rs1),
    .o_rs2_rnid (ren_rs2),
    .o_rd_rnid  (ren_rd),
    .o_old_rnid (ren_old),
    .i_phy_wr   (phy_wr)
  );

  phy_registers #(.REG_TYPE(GPR)) gpr_regs_i (
    .i_clk     (i_clk),
    .i_reset_n (i_reset_n),
    .i_rd_rnid (rd_rnid),
    .o_rd_data (gpr_rd_data),
    .i_phy_wr  (phy_wr)
  );

  phy_registers #(.REG_TYPE(FPR)) fpr_regs_i (
    .i_clk     (i_clk),
    .i_reset_n (i_reset_n),
    .i_rd_rnid (rd_rnid),
    .o_rd_data (fpr_rd_data),
    .i_phy_wr  (phy_wr)
  );

  exec_units exec_units_i (
    .i_clk         (i_clk),
    .i_reset_n     (i_reset_n),
    .i_issue       (issue),
    .i_gpr_rd_data (gpr_rd_data),
    .i_fpr_rd_data (fpr_rd_data),
    .o_phy_wr      (phy_wr)
  );

  // Each target bus is reported as it writes.
  for (genvar w = 0; w < TGT_BUS_SIZE; w++) begin : g_wb
    assign o_wb[w].valid   = phy_wr[w].valid;
    assign o_wb[w].tag     = phy_wr[w].tag;
    assign o_wb[w].rd_type = phy_wr[w].rd_type;
    assign o_wb[w].rd_arch = phy_wr[w].rd_arch;
    assign o_wb[w].data    = phy_wr[w].rd_data;
  end

endmodule

/* verif/rn_backend_checks.svh */
// Back end testbench checks: in-order reference model, report matching and typed compares.
`ifndef RN_BACKEND_CHECKS_SVH
`define RN_BACKEND_CHECKS_SVH

  function automatic string test_label(int t);
    case (t)
      0:       return "arithmetic";
      1:       return "dependencies";
      2:       return "x0 writes";
      3:       return "cross-bank moves";
      4:       return "register reuse";
      default: return "completeness";
    endcase
  endfunction

  // Walks the table in program order over the two architectural banks.
  task automatic build_expected();
    data_t       gpr [ARCH_REGS];
    data_t       fpr [ARCH_REGS];
    data_t       res;
    logic [63:0] prod;
    logic        to_fpr;
    uop_t        u;
    for (int a = 0; a < ARCH_REGS; a++) begin
      gpr[a] = '0;
      fpr[a] = '0;
    end
    for (int i = 0; i < n_added; i++) begin
      u    = vec_tbl[i].uop;
      prod = 64'(gpr[u.rs1]) * 64'(gpr[u.rs2]);
      case (u.opcode)
        OP_ADD:   res = gpr[u.rs1] + gpr[u.rs2];
        OP_SUB:   res = gpr[u.rs1] - gpr[u.rs2];
        OP_XOR:   res = gpr[u.rs1] ^ gpr[u.rs2];
        OP_LI:    res = {16'h0000, u.imm};
        OP_MUL:   res = prod[31:0];
        OP_FADD:  res = fpr[u.rs1] + fpr[u.rs2];
        OP_FMVXF: res = gpr[u.rs1];
        OP_FMVFX: res = fpr[u.rs1];
        default:  res = '0;
      endcase
      to_fpr = (u.opcode == OP_FADD) || (u.opcode == OP_FMVXF);
      // x0 keeps reading zero, the report still carries the result
      if (to_fpr) begin
        fpr[u.rd] = res;
      end else if (u.rd != '0) begin
        gpr[u.rd] = res;
      end
      vec_tbl[i].exp.valid   = 1'b1;
      vec_tbl[i].exp.tag     = u.tag;
      vec_tbl[i].exp.rd_type = to_fpr ? FPR : GPR;
      vec_tbl[i].exp.rd_arch = u.rd;
      vec_tbl[i].exp.data    = res;
    end
  endtask

  task automatic check_wb(input int bus, input wb_info_t got, input wb_info_t exp,
                          inout int n_bad);
    if (got.rd_type != exp.rd_type) begin
      $display("FAILED %0t o_wb[%0d].rd_type got %0d expected %0d",
               $time, bus, got.rd_type, exp.rd_type);
      n_bad++;
      errors++;
    end
    if (got.rd_arch != exp.rd_arch) begin
      $display("FAILED %0t o_wb[%0d].rd_arch got %0d expected %0d",
               $time, bus, got.rd_arch, exp.rd_arch);
      n_bad++;
      errors++;
    end
    if (got.data != exp.data) begin
      $display("FAILED %0t o_wb[%0d].data got %h expected %h", $time, bus, got.data, exp.data);
      n_bad++;
      errors++;
    end
  endtask

  task automatic check_count(input string name, input int got, input int exp, inout int n_bad);
    if (got != exp) begin
      $display("FAILED %0t %s got %0d expected %0d", $time, name, got, exp);
      n_bad++;
      errors++;
    end
  endtask

  task automatic report_test(input int num, input int n_bad);
    if (n_bad == 0) begin
      $display("Test %0d %s: ok", num, test_label(num - 1));
    end else begin
      $display("Test %0d %s: %0d errors", num, test_label(num - 1), n_bad);
    end
  endtask

  // Matches a strobe to the outstanding micro-op with the same tag.
  task automatic take_report(input int bus, input wb_info_t got);
    int idx;
    int t;
    idx = pend_idx[got.tag];
    if (idx < 0) begin
      extra_reports++;
      errors++;
      $display("Unexpected report on o_wb[%0d] at %0t for tag %0d with nothing outstanding",
               bus, $time, got.tag);
    end else begin
      t = int'(vec_tbl[idx].test);
      check_wb(bus, got, vec_tbl[idx].exp, test_err[t]);
      pend_idx[got.tag] = -1;
      reported++;
      left[t]--;
      if (left[t] == 0) begin
        report_test(t + 1, test_err[t]);
      end
    end
  endtask

  task automatic finish_tests();
    int n_bad;
    n_bad = 0;
    for (int t = 0; t < N_TESTS; t++) begin
      if (left[t] != 0) begin
        errors++;
        $display("Test %0d %s: %0d reports never arrived", t + 1, test_label(t), left[t]);
      end
    end
    check_count("reported micro-ops", reported, N_OPS, n_bad);
    check_count("unexpected reports", extra_reports, 0, n_bad);
    report_test(N_TESTS + 1, n_bad);
  endtask

`endif

/* verif/rn_backend_tb.sv */
// Back end testbench: drives a micro-op table and matches write-back reports by tag.
`timescale 1ns/10ps

module rn_backend_tb;

  import rn_cfg_pkg::*;
  import rn_uop_pkg::*;

  localparam int N_OPS      = 25;
  localparam int N_TESTS    = 5;
  localparam int N_TAGS     = 2**TAG_W;
  localparam int MAX_OUT    = 8;
  localparam int WAIT_LIMIT = 200;

  // One table row: test group, micro-op to send and its expected report.
  typedef struct packed {
    logic [2:0] test;
    uop_t       uop;
    wb_info_t   exp;
  } vec_t;

  logic     i_clk;
  logic     i_reset_n;
  uop_t     i_uop;
  wb_info_t o_wb [TGT_BUS_SIZE];

  vec_t   vec_tbl  [N_OPS];
  int     pend_idx [N_TAGS];
  int     left     [N_TESTS];
  int     test_err [N_TESTS];
  int     n_added;
  int     sent;
  int     reported;
  int     extra_reports;
  int     errors;
  logic   timed_out;
  integer seed;

  `include "rn_backend_checks.svh"

  rn_backend_top rn_backend_top_i (
    .i_clk     (i_clk),
    .i_reset_n (i_reset_n),
    .i_uop     (i_uop),
    .o_wb      (o_wb)
  );

  initial i_clk = 1'b0;
  always #2 i_clk = ~i_clk;

  task automatic add_op(input int test, input opcode_e op, input int rd, input int rs1,
                        input int rs2, input logic [15:0] imm);
    vec_tbl[n_added].test       = 3'(test);
    vec_tbl[n_added].uop.valid  = 1'b1;
    vec_tbl[n_added].uop.tag    = TAG_W'(n_added);
    vec_tbl[n_added].uop.opcode = op;
    vec_tbl[n_added].uop.rd     = ARCH_W'(rd);
    vec_tbl[n_added].uop.rs1    = ARCH_W'(rs1);
    vec_tbl[n_added].uop.rs2    = ARCH_W'(rs2);
    vec_tbl[n_added].uop.imm    = imm;
    vec_tbl[n_added].exp        = '0;
    left[test]++;
    n_added++;
  endtask

  // Columns: test, opcode, rd, rs1, rs2, immediate.
  task automatic load_table();
    add_op(0, OP_LI,    1, 0, 0, 16'hFFFF);
    add_op(0, OP_LI,    2, 0, 0, 16'h1234);
    add_op(0, OP_ADD,   3, 1, 2, 16'h0000);
    add_op(0, OP_SUB,   4, 2, 1, 16'h0000);
    add_op(0, OP_XOR,   5, 1, 2, 16'h0000);
    add_op(0, OP_MUL,   6, 1, 1, 16'h0000);
    add_op(1, OP_MUL,   7, 6, 3, 16'h0000);
    add_op(1, OP_ADD,   1, 7, 6, 16'h0000);
    add_op(1, OP_SUB,   2, 1, 7, 16'h0000);
    add_op(2, OP_LI,    0, 0, 0, 16'hBEEF);
    add_op(2, OP_MUL,   0, 2, 2, 16'h0000);
    add_op(2, OP_ADD,   5, 0, 2, 16'h0000);
    add_op(3, OP_FMVXF, 1, 6, 0, 16'h0000);
    add_op(3, OP_FMVXF, 2, 4, 0, 16'h0000);
    add_op(3, OP_FADD,  3, 1, 2, 16'h0000);
    add_op(3, OP_FMVFX, 7, 3, 0, 16'h0000);
    add_op(4, OP_LI,    3, 0, 0, 16'h0005);
    for (int k = 0; k < 7; k++) begin
      add_op(4, OP_ADD, 3, 3, 3, 16'h0000);
    end
    add_op(4, OP_MUL,   3, 3, 7, 16'h0000);
  endtask

  // Reports are sampled mid-cycle, away from the driving edge.
  always @(negedge i_clk) begin
    if (i_reset_n) begin
      for (int w = 0; w < TGT_BUS_SIZE; w++) begin
        if (o_wb[w].valid) begin
          take_report(w, o_wb[w]);
        end
      end
    end
  end

  initial begin
    int gap;
    int waited;
    seed          = 32'h7711_8501;
    i_reset_n     = 1'b0;
    i_uop         = '0;
    n_added       = 0;
    sent          = 0;
    reported      = 0;
    extra_reports = 0;
    errors        = 0;
    timed_out     = 1'b0;
    for (int t = 0; t < N_TAGS; t++) begin
      pend_idx[t] = -1;
    end
    for (int t = 0; t < N_TESTS; t++) begin
      left[t]     = 0;
      test_err[t] = 0;
    end
    load_table();
    build_expected();
    repeat (3) @(posedge i_clk);
    i_reset_n <= 1'b1;

    // Random idle gaps, and never more than eight micro-ops in flight.
    for (int i = 0; i < N_OPS && !timed_out; i++) begin
      gap    = $random(seed) & 3;
      waited = 0;
      while ((gap > 0 || (sent - reported) >= MAX_OUT) && !timed_out) begin
        @(posedge i_clk);
        i_uop <= '0;
        gap--;
        waited++;
        if (waited > WAIT_LIMIT) begin
          timed_out = 1'b1;
          $display("Timeout: no room to send micro-op %0d, %0d still outstanding",
                   i, sent - reported);
        end
      end
      if (!timed_out) begin
        @(posedge i_clk);
        i_uop <= vec_tbl[i].uop;
        pend_idx[vec_tbl[i].uop.tag] = i;
        sent++;
      end
    end
    @(posedge i_clk);
    i_uop <= '0;

    waited = 0;
    while (reported < N_OPS && !timed_out) begin
      @(posedge i_clk);
      waited++;
      if (waited > WAIT_LIMIT) begin
        timed_out = 1'b1;
        $display("Timeout: only %0d of %0d micro-ops were reported", reported, N_OPS);
      end
    end
    // Quiet window; any strobe here counts as unexpected.
    repeat (20) @(posedge i_clk);
    finish_tests();

    $display("Summary: %0d sent, %0d reported, %0d unexpected, %0d errors",
             sent, reported, extra_reports, errors);
    if (errors == 0 && !timed_out) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

/* build.f */
+incdir+verif
source/rn_cfg_pkg.sv
source/rn_uop_pkg.sv
source/phy_registers.sv
source/rename_map.sv
source/exec_units.sv
source/issue_ctrl.sv
source/rn_backend_top.sv
verif/rn_backend_tb.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= rn_backend_tb
FILELIST  ?= build.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  := Testbench passed

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list these targets"
	@echo "  test   build with Verilator, run, and search the log for the pass message"
	@echo "  clean  remove the build directory and the log"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "Simulation did not pass"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
